// ==== rtl/core_pkg.sv ====
package core_pkg;

  // architectural widths
  localparam int XLEN = 64;
  localparam int ILEN = 32;

  // byte step of one sequential fetch
  localparam int INST_BYTES = ILEN / 8;

  // addi x0, x0, 0
  // handed downstream whenever the fetch slot is empty
  localparam logic [ILEN-1:0] NOP_INST = 32'h0000_0013;

  // control transfer from a later stage
  // covers jal, jalr, mret and ecall alike
  typedef struct packed {
    // strobe, one cycle per redirect
    logic            valid;
    // new fetch address
    logic [XLEN-1:0] target;
  } redirect_t;

endpackage

// ==== rtl/icache_pkg.sv ====
package icache_pkg;

  // one line holds two instructions
  localparam int LINE_BYTES = 8;
  localparam int OFS_W      = $clog2(LINE_BYTES);

  // field layout sized for the largest cache (64 sets)
  // smaller caches fold the unused index bits into the tag
  localparam int MAX_IDX_W = 6;
  localparam int MAX_TAG_W = core_pkg::XLEN - MAX_IDX_W - OFS_W;

  // fetch address split for lookup
  typedef struct packed {
    logic [MAX_TAG_W-1:0] tag;
    logic [MAX_IDX_W-1:0] index;
    // bit 2 picks the instruction half
    logic [OFS_W-1:0]     offset;
  } fetch_fields_t;

  // same word, seen as plain pc or as lookup fields
  typedef union packed {
    logic [core_pkg::XLEN-1:0] raw;
    fetch_fields_t             f;
  } fetch_addr_u;

  // refill unit from memory
  // lo sits at the lower address (little endian)
  typedef struct packed {
    logic [core_pkg::ILEN-1:0] hi;
    logic [core_pkg::ILEN-1:0] lo;
  } line_t;

endpackage

// ==== rtl/pc_gen.sv ====
`timescale 1ns/10ps

module pc_gen #(
  parameter logic [core_pkg::XLEN-1:0] RESET_PC = 64'h0000_0000_8000_0000
) (
  input  logic                    clk,
  input  logic                    rst_n,
  // from the later stage
  input  core_pkg::redirect_t     redirect_i,
  // current instruction accepted downstream
  input  logic                    advance_i,
  output icache_pkg::fetch_addr_u pc_o
);

  // architectural fetch pointer
  icache_pkg::fetch_addr_u pc_q;
  logic [core_pkg::XLEN-1:0] pc_next;
  logic [core_pkg::XLEN-1:0] pc_seq;

  // sequential successor
  assign pc_seq = pc_q.raw + core_pkg::XLEN'(core_pkg::INST_BYTES);

  // redirect wins over advance, otherwise hold
  // holding covers both stall and miss
  always_comb begin
    pc_next = pc_q.raw;
    if (redirect_i.valid) begin
      pc_next = redirect_i.target;
    end else if (advance_i) begin
      pc_next = pc_seq;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q.raw <= RESET_PC;
    end else begin
      pc_q.raw <= pc_next;
    end
  end

  // straight to both arrays and the controller
  assign pc_o = pc_q;

endmodule

// ==== rtl/icache_tag_array.sv ====
`timescale 1ns/10ps

module icache_tag_array #(
  parameter int SETS = 16
) (
  input  logic                    clk,
  input  logic                    rst_n,
  // lookup address
  input  icache_pkg::fetch_addr_u pc_i,
  // fence.i style invalidate
  input  logic                    flush_i,
  // refill done, mark the set
  input  logic                    set_valid_i,
  input  icache_pkg::fetch_addr_u set_addr_i,
  output logic                    hit_o
);

  localparam int IDX_W = $clog2(SETS);
  // spare index bits land in the stored tag
  localparam int TAG_W = core_pkg::XLEN - icache_pkg::OFS_W - IDX_W;
  localparam int TAG_LSB = icache_pkg::OFS_W + IDX_W;

  logic [SETS-1:0]  valid_q;
  logic [TAG_W-1:0] tag_q [SETS];

  logic [IDX_W-1:0] rd_idx;
  logic [TAG_W-1:0] rd_tag;
  logic [IDX_W-1:0] wr_idx;
  logic [TAG_W-1:0] wr_tag;

  // index from the field view, tag from the raw view
  assign rd_idx = pc_i.f.index[IDX_W-1:0];
  assign rd_tag = pc_i.raw[core_pkg::XLEN-1:TAG_LSB];
  assign wr_idx = set_addr_i.f.index[IDX_W-1:0];
  assign wr_tag = set_addr_i.raw[core_pkg::XLEN-1:TAG_LSB];

  // flush beats a same-cycle set
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else if (flush_i) begin
      valid_q <= '0;
    end else if (set_valid_i) begin
      valid_q[wr_idx] <= 1'b1;
    end
  end

  // tag storage, only meaningful under valid
  always_ff @(posedge clk) begin
    if (set_valid_i) begin
      tag_q[wr_idx] <= wr_tag;
    end
  end

  // combinational compare, same cycle as pc
  assign hit_o = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);

endmodule

// ==== rtl/icache_data_array.sv ====
`timescale 1ns/10ps

module icache_data_array #(
  parameter int SETS = 16
) (
  input  logic                      clk,
  // read address
  input  icache_pkg::fetch_addr_u   pc_i,
  // refill write
  input  logic                      wr_en_i,
  input  icache_pkg::fetch_addr_u   wr_addr_i,
  input  icache_pkg::line_t         wr_line_i,
  output logic [core_pkg::ILEN-1:0] inst_o
);

  localparam int IDX_W = $clog2(SETS);

  // one line per set
  icache_pkg::line_t lines_q [SETS];
  icache_pkg::line_t rd_line;

  // whole line written at once
  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      lines_q[wr_addr_i.f.index[IDX_W-1:0]] <= wr_line_i;
    end
  end

  // async read
  assign rd_line = lines_q[pc_i.f.index[IDX_W-1:0]];

  // offset bit 2 selects upper word
  assign inst_o = pc_i.f.offset[2] ? rd_line.hi : rd_line.lo;

endmodule

// ==== rtl/icache_ctrl.sv ====
`timescale 1ns/10ps

module icache_ctrl (
  input  logic                      clk,
  input  logic                      rst_n,
  input  icache_pkg::fetch_addr_u   pc_i,
  // from tag array
  input  logic                      hit_i,
  // downstream back-pressure
  input  logic                      stall_i,
  // memory read port
  input  logic                      mem_valid_i,
  input  icache_pkg::line_t         mem_data_i,
  output logic                      mem_req_o,
  output logic [core_pkg::XLEN-1:0] mem_addr_o,
  // refill into the arrays
  output logic                      fill_en_o,
  output icache_pkg::fetch_addr_u   fill_addr_o,
  output icache_pkg::line_t         fill_line_o,
  // fetch result
  output logic                      inst_valid_o,
  output logic                      advance_o
);

  // refill fsm encoding
  localparam logic S_IDLE = 1'b0;
  localparam logic S_WAIT = 1'b1;

  logic state_q;
  logic state_d;
  // goes high on the first edge out of reset
  // keeps the port quiet while reset is held
  logic run_q;
  // address of the line in flight
  icache_pkg::fetch_addr_u req_addr_q;

  logic miss;

  // lookup only counts with no refill pending
  assign inst_valid_o = hit_i && (state_q == S_IDLE);
  assign miss         = run_q && !hit_i && (state_q == S_IDLE);

  // pc moves only on an accepted instruction
  assign advance_o = inst_valid_o && !stall_i;

  // one-cycle request on the first miss cycle
  assign mem_req_o  = miss;
  assign mem_addr_o = {pc_i.raw[core_pkg::XLEN-1:icache_pkg::OFS_W],
                       {icache_pkg::OFS_W{1'b0}}};

  // fill on the edge that samples the response
  // uses the latched address, not the current pc
  // so a redirect mid-refill still fills its own line
  assign fill_en_o   = mem_valid_i && (state_q == S_WAIT);
  assign fill_addr_o = req_addr_q;
  assign fill_line_o = mem_data_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      S_IDLE: begin
        if (miss) begin
          state_d = S_WAIT;
        end
      end
      default: begin
        if (mem_valid_i) begin
          state_d = S_IDLE;
        end
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= S_IDLE;
      run_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      run_q   <= 1'b1;
    end
  end

  // request address capture
  always_ff @(posedge clk) begin
    if (miss) begin
      req_addr_q.raw <= mem_addr_o;
    end
  end

endmodule

// ==== rtl/if_stage.sv ====
`timescale 1ns/10ps

module if_stage #(
  parameter int                        SETS     = 16,
  parameter logic [core_pkg::XLEN-1:0] RESET_PC = 64'h0000_0000_8000_0000
) (
  input  logic                      clk,
  input  logic                      rst_n,
  // later stage control
  input  core_pkg::redirect_t       redirect_i,
  input  logic                      stall_i,
  input  logic                      flush_i,
  // to decode
  output logic [core_pkg::XLEN-1:0] pc_o,
  output logic [core_pkg::ILEN-1:0] inst_o,
  output logic                      inst_valid_o,
  // memory read port
  output logic                      mem_req_o,
  output logic [core_pkg::XLEN-1:0] mem_addr_o,
  input  logic                      mem_valid_i,
  input  icache_pkg::line_t         mem_data_i
);

  icache_pkg::fetch_addr_u   pc;
  icache_pkg::fetch_addr_u   fill_addr;
  icache_pkg::line_t         fill_line;
  logic                      fill_en;
  logic                      tag_hit;
  logic                      advance;
  logic [core_pkg::ILEN-1:0] arr_inst;

  pc_gen #(
    .RESET_PC (RESET_PC)
  ) i_pc_gen (
    .clk        (clk),
    .rst_n      (rst_n),
    .redirect_i (redirect_i),
    .advance_i  (advance),
    .pc_o       (pc)
  );

  // tag and data looked up in parallel
  icache_tag_array #(
    .SETS (SETS)
  ) i_tag_array (
    .clk         (clk),
    .rst_n       (rst_n),
    .pc_i        (pc),
    .flush_i     (flush_i),
    .set_valid_i (fill_en),
    .set_addr_i  (fill_addr),
    .hit_o       (tag_hit)
  );

  icache_data_array #(
    .SETS (SETS)
  ) i_data_array (
    .clk       (clk),
    .pc_i      (pc),
    .wr_en_i   (fill_en),
    .wr_addr_i (fill_addr),
    .wr_line_i (fill_line),
    .inst_o    (arr_inst)
  );

  icache_ctrl i_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .pc_i         (pc),
    .hit_i        (tag_hit),
    .stall_i      (stall_i),
    .mem_valid_i  (mem_valid_i),
    .mem_data_i   (mem_data_i),
    .mem_req_o    (mem_req_o),
    .mem_addr_o   (mem_addr_o),
    .fill_en_o    (fill_en),
    .fill_addr_o  (fill_addr),
    .fill_line_o  (fill_line),
    .inst_valid_o (inst_valid_o),
    .advance_o    (advance)
  );

  assign pc_o = pc.raw;

  // bubble as nop while the slot is empty
  assign inst_o = inst_valid_o ? arr_inst : core_pkg::NOP_INST;

endmodule

// ==== test/tb_clk.sv ====
`timescale 1ns/10ps

module tb_clk #(
  parameter int PERIOD_NS = 40
) (
  output logic clk_o
);

  // free running, starts low
  initial begin
    clk_o = 1'b0;
    forever begin
      #(PERIOD_NS / 2) clk_o = ~clk_o;
    end
  end

endmodule

// ==== test/if_stage_chk.sv ====
`timescale 1ns/10ps

module if_stage_chk (
  input logic                      clk,
  input logic                      rst_n,
  input core_pkg::redirect_t       redirect_i,
  input logic                      stall_i,
  input logic [core_pkg::XLEN-1:0] pc_i,
  input logic [core_pkg::ILEN-1:0] inst_i,
  input logic                      inst_valid_i,
  input logic                      mem_req_i,
  input logic                      mem_valid_i
);

  // refill in flight, set by request, cleared by response
  logic busy_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q <= 1'b0;
    end else if (mem_req_i) begin
      busy_q <= 1'b1;
    end else if (mem_valid_i) begin
      busy_q <= 1'b0;
    end
  end

  a_single_req: assert property (@(posedge clk) disable iff (!rst_n)
    busy_q |-> !mem_req_i)
    else $error("memory request issued while a refill is outstanding");

  // empty slot carries the nop
  a_bubble_nop: assert property (@(posedge clk) disable iff (!rst_n)
    !inst_valid_i |-> inst_i == core_pkg::NOP_INST)
    else $error("empty fetch slot does not carry the nop");

  a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
    stall_i && !redirect_i.valid |=> $stable(pc_i))
    else $error("pc moved after a stalled cycle without redirect");

endmodule

bind if_stage if_stage_chk i_chk (
  .clk          (clk),
  .rst_n        (rst_n),
  .redirect_i   (redirect_i),
  .stall_i      (stall_i),
  .pc_i         (pc_o),
  .inst_i       (inst_o),
  .inst_valid_i (inst_valid_o),
  .mem_req_i    (mem_req_o),
  .mem_valid_i  (mem_valid_i)
);

// ==== test/tb_if_stage.sv ====
`timescale 1ns/10ps

module tb_if_stage;

  localparam logic [63:0] RESET_PC = 64'h0000_0000_8000_0000;
  localparam logic [63:0] ALIAS_A  = 64'h0000_0000_8000_4000;
  // same set as ALIAS_A with 4 sets of 8 bytes
  localparam logic [63:0] ALIAS_B  = 64'h0000_0000_8000_4400;
  localparam logic [63:0] FLUSH_C  = 64'h0000_0000_8000_6000;
  // total accepts times worst miss cycles with slack for stalls and redirects
  localparam int TOTAL_ACCEPTS   = 172;
  localparam int MAX_MISS_CYCLES = 12;
  localparam int WATCHDOG_NS     = TOTAL_ACCEPTS * MAX_MISS_CYCLES * 4 * 40;

  logic                clk;
  logic                rst_n;
  core_pkg::redirect_t redirect;
  logic                stall;
  logic                flush;
  logic [63:0]         pc;
  logic [31:0]         inst;
  logic                inst_valid;
  logic                mem_req;
  logic [63:0]         mem_addr;
  logic                mem_valid;
  icache_pkg::line_t   mem_data;

  string       test_name = "reset";
  int          errors = 0;
  // instructions taken downstream so far
  int          accepted;
  logic [15:0] stim_lfsr;
  // line addresses in request order
  logic [63:0] req_log [$];

  tb_clk #(.PERIOD_NS (40)) i_clk (.clk_o (clk));

  if_stage #(
    .SETS     (4),
    .RESET_PC (RESET_PC)
  ) i_dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .redirect_i   (redirect),
    .stall_i      (stall),
    .flush_i      (flush),
    .pc_o         (pc),
    .inst_o       (inst),
    .inst_valid_o (inst_valid),
    .mem_req_o    (mem_req),
    .mem_addr_o   (mem_addr),
    .mem_valid_i  (mem_valid),
    .mem_data_i   (mem_data)
  );

  // memory content per word address
  function automatic logic [31:0] mem_word(input logic [63:0] addr);
    logic [63:0] wa;
    wa = addr >> 2;
    // invertible so no two words share a value
    return {wa[31:16] ^ wa[15:0], wa[15:0]} ^ 32'hC3A5_5A3C;
  endfunction

  // galois form with taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic draw_bits(inout logic [15:0] state, input int n, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < n; i++) begin
      value = {value[30:0], state[0]};
      state = lfsr_step(state);
    end
  endtask

  function automatic int count_requests(input logic [63:0] line);
    int n;
    n = 0;
    foreach (req_log[k]) begin
      if (req_log[k] == line) begin
        n++;
      end
    end
    return n;
  endfunction

  task automatic check_value(input string what, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      errors++;
      $display("FAILED %s %s: expected %h, actual %h", test_name, what, expected, actual);
      $display("Verification failed");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  // entered and left on a falling edge
  task automatic wait_accepts(input int n, input logic random_stall);
    int          target;
    logic [31:0] rnd;
    target = accepted + n;
    while (accepted < target) begin
      if (random_stall) begin
        draw_bits(stim_lfsr, 1, rnd);
        stall = rnd[0];
      end
      @(negedge clk);
    end
    stall = 1'b0;
  endtask

  // one-cycle strobe with optional invalidate
  task automatic send_redirect(input logic [63:0] target, input logic with_flush);
    redirect.valid  = 1'b1;
    redirect.target = target;
    flush           = with_flush;
    @(negedge clk);
    redirect.valid = 1'b0;
    flush          = 1'b0;
  endtask

  always @(posedge clk) begin
    if (rst_n && mem_req) begin
      req_log.push_back(mem_addr);
    end
  end

  // serves logged requests one at a time 1 to 8 cycles late
  initial begin : memory_model
    logic [15:0] lfsr;
    logic [31:0] delay;
    logic [63:0] line_addr;
    int          served;
    int          cnt;
    logic        busy;
    lfsr      = 16'd22;
    served    = 0;
    cnt       = 0;
    busy      = 1'b0;
    line_addr = '0;
    mem_valid = 1'b0;
    mem_data  = '0;
    forever begin
      @(negedge clk);
      mem_valid = 1'b0;
      if (!busy && req_log.size() > served) begin
        line_addr = req_log[served];
        served++;
        draw_bits(lfsr, 3, delay);
        cnt  = int'(delay) + 1;
        busy = 1'b1;
      end
      if (busy) begin
        if (cnt == 1) begin
          mem_valid   = 1'b1;
          mem_data.lo = mem_word(line_addr);
          mem_data.hi = mem_word(line_addr + 64'd4);
          busy        = 1'b0;
        end else begin
          cnt--;
        end
      end
    end
  end

  // outputs and strobes are all settled at the rising edge
  initial begin : compare
    logic [63:0] model_pc;
    logic        hold_q;
    model_pc = RESET_PC;
    accepted = 0;
    hold_q   = 1'b0;
    forever begin
      @(posedge clk);
      if (rst_n) begin
        check_value("pc", model_pc, pc);
        // stalled slot keeps its pc and its word
        if (hold_q) begin
          check_value("held valid", 64'd1, 64'(inst_valid));
          check_value("held inst", 64'(mem_word(model_pc)), 64'(inst));
        end
        if (inst_valid && !stall) begin
          check_value("inst", 64'(mem_word(model_pc)), 64'(inst));
          accepted++;
        end
        hold_q = stall && inst_valid && !redirect.valid && !flush;
        // redirect before advance before hold
        if (redirect.valid) begin
          model_pc = redirect.target;
        end else if (inst_valid && !stall) begin
          model_pc = model_pc + 64'd4;
        end
      end
    end
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("timeout: test %s did not finish within %0d ns", test_name, WATCHDOG_NS);
    $display("Verification failed");
    $fatal(1, "watchdog expired");
  end

  initial begin : stimulus
    logic [31:0] rnd;
    int          n0;
    stim_lfsr = 16'd22;
    rst_n     = 1'b0;
    redirect  = '0;
    stall     = 1'b0;
    flush     = 1'b0;
    @(negedge clk);
    check_value("pc", RESET_PC, pc);
    check_value("valid", 64'd0, 64'(inst_valid));
    check_value("request", 64'd0, 64'(mem_req));
    @(negedge clk);
    rst_n = 1'b1;

    // cold cache fetches 20 lines in order with none twice
    test_name = "sequential";
    wait_accepts(40, 1'b0);
    for (int i = 0; i < 20; i++) begin
      check_value("line request", RESET_PC + 64'(8 * i), req_log[i]);
    end

    test_name = "redirect";
    for (int r = 0; r < 12; r++) begin
      // untouched line so the miss is certain
      send_redirect(64'h0000_0000_8000_8000 + 64'(r * 64), 1'b0);
      n0 = req_log.size();
      while (req_log.size() == n0) begin
        @(negedge clk);
      end
      // refill still in flight here
      draw_bits(stim_lfsr, 10, rnd);
      send_redirect(RESET_PC + 64'({rnd[9:0], 2'b00}), 1'b0);
      wait_accepts(3, 1'b0);
    end

    test_name = "stall";
    send_redirect(64'h0000_0000_8000_2000, 1'b0);
    wait_accepts(30, 1'b1);

    // two lines fighting for set 0
    test_name = "alias";
    for (int r = 0; r < 3; r++) begin
      send_redirect(ALIAS_A, 1'b0);
      wait_accepts(8, 1'b0);
      send_redirect(ALIAS_B, 1'b0);
      wait_accepts(8, 1'b0);
    end
    check_value("requests of line a", 64'd3, 64'(count_requests(ALIAS_A)));
    check_value("requests of line b", 64'd3, 64'(count_requests(ALIAS_B)));

    test_name = "flush";
    send_redirect(FLUSH_C, 1'b0);
    wait_accepts(6, 1'b0);
    send_redirect(FLUSH_C, 1'b0);
    wait_accepts(6, 1'b0);
    check_value("requests before flush", 64'd1, 64'(count_requests(FLUSH_C)));
    send_redirect(FLUSH_C, 1'b1);
    wait_accepts(6, 1'b0);
    check_value("requests after flush", 64'd2, 64'(count_requests(FLUSH_C)));

    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// ==== list.f ====
rtl/core_pkg.sv
rtl/icache_pkg.sv
rtl/pc_gen.sv
rtl/icache_tag_array.sv
rtl/icache_data_array.sv
rtl/icache_ctrl.sv
rtl/if_stage.sv
test/tb_clk.sv
test/if_stage_chk.sv
test/tb_if_stage.sv

// ==== run.sh ====
#!/bin/sh
# builds the fetch stage testbench with verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --timescale 1ns/10ps \
  --top-module tb_if_stage \
  -f list.f \
  -o tb_if_stage_sim

./obj_dir/tb_if_stage_sim | tee sim.log

if grep -q "Verification failed" sim.log; then
  echo "simulation reported a failure, see sim.log"
  exit 1
fi
if ! grep -q "Verification passed" sim.log; then
  echo "simulation ended without a result, see sim.log"
  exit 1
fi
